/* src/spi_bridge_cfg.svh */
/*
 Register map, mailbox geometry and identity values of the SPI register bridge.
 Included by the package, by the RTL that decodes addresses and by the testbench model.
*/
`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

// register map
`define CHIP_ID_ADDRESS   8'h01
`define VERSION_ADDRESS   8'h02
`define SLOT_BASE_ADDRESS 8'h10

// mailbox slots, slot i sits at base + i
`define SLOT_COUNT 4
`define SLOT_DEPTH 8

// identity block contents
`define CHIP_ID_VALUE  8'h81
`define VERSION_STRING "v1.0"
`define VERSION_LENGTH 4

// answer for any address with no block behind it
`define UNMAPPED_VALUE 8'hFF

`endif

/* src/spi_bridge_pkg.sv */
/*
 Shared types of the SPI register bridge: byte and address widths, the slot
 enable vector, and the request and response structs between peripheral and blocks.
*/
`include "spi_bridge_cfg.svh"

package spi_bridge_pkg;

    // one byte on the SPI side or the register side
    typedef logic [7:0] byte_t;

    // register address, the first byte of every transaction
    typedef logic [7:0] spi_address_t;

    // one enable per mailbox slot
    typedef logic [`SLOT_COUNT-1:0] slot_enable_t;

    // peripheral to register blocks, strobes are single cycle
    typedef struct packed {
        spi_address_t address;
        logic         address_valid;
        byte_t        data;
        logic         data_valid;
    } sub_request_t;

    // register block back to peripheral, valid one cycle after a strobe
    typedef struct packed {
        byte_t data;
        logic  valid;
    } sub_response_t;

endpackage

/* src/spi_peripheral.sv */
/*
 SPI mode 0 peripheral oversampled on oscillator_clock. Shifts bytes in and out MSB
 first, strobes the first byte as an address and every later byte as data.
*/
`timescale 1ns/1ns

module spi_peripheral (
    input  logic                          oscillator_clock,
    input  logic                          rst_n,
    input  logic                          spi_select_in,
    input  logic                          spi_clock_in,
    input  logic                          spi_data_in,
    output logic                          spi_data_out,
    output logic                          transaction_active,
    output spi_bridge_pkg::sub_request_t  request,
    input  spi_bridge_pkg::sub_response_t response
);
    import spi_bridge_pkg::*;

    // two flop synchronizers, bit 1 is the usable copy
    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_prev;

    logic       clock_rise;
    logic       clock_fall;

    logic [2:0] bit_count;
    logic       byte_done;
    logic       address_received;

    byte_t      rx_shift;
    byte_t      tx_shift;
    byte_t      tx_next;

    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            select_sync <= 2'b11;
            clock_sync  <= 2'b00;
            data_sync   <= 2'b00;
            clock_prev  <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select_in};
            clock_sync  <= {clock_sync[0], spi_clock_in};
            data_sync   <= {data_sync[0], spi_data_in};
            clock_prev  <= clock_sync[1];
        end
    end

    assign transaction_active = !select_sync[1];

    // edges only count inside a transaction
    assign clock_rise = transaction_active && clock_sync[1] && !clock_prev;
    assign clock_fall = transaction_active && !clock_sync[1] && clock_prev;

    // bit counter, byte_done marks the eighth rising edge
    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            bit_count <= 3'd0;
            byte_done <= 1'b0;
        end else if (!transaction_active) begin
            bit_count <= 3'd0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= clock_rise && (bit_count == 3'd7);
            if (clock_rise) begin
                bit_count <= bit_count + 3'd1;
            end
        end
    end

    always_ff @(posedge oscillator_clock) begin
        if (clock_rise) begin
            rx_shift <= {rx_shift[6:0], data_sync[1]};
        end
    end

    // first byte of a transaction is the address, the rest is data
    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            request          <= '0;
            address_received <= 1'b0;
        end else begin
            request.address_valid <= 1'b0;
            request.data_valid    <= 1'b0;
            if (!transaction_active) begin
                address_received <= 1'b0;
            end else if (byte_done) begin
                if (!address_received) begin
                    request.address       <= rx_shift;
                    request.address_valid <= 1'b1;
                    address_received      <= 1'b1;
                end else begin
                    request.data       <= rx_shift;
                    request.data_valid <= 1'b1;
                end
            end
        end
    end

    // transmit side, the response lands in tx_next and is loaded
    // on the falling edge that follows the eighth rising edge
    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
            tx_next  <= '0;
        end else if (!transaction_active) begin
            tx_shift <= '0;
            tx_next  <= '0;
        end else begin
            if (response.valid) begin
                tx_next <= response.data;
            end
            if (clock_fall) begin
                if (bit_count == 3'd0) begin
                    tx_shift <= tx_next;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    assign spi_data_out = tx_shift[7];

endmodule

/* src/subperipheral_selector.sv */
/*
 Address decode for the bridge. Latches the target on the address strobe, holds its
 enable until chip select rises and steers the enabled target's response back.
*/
`timescale 1ns/1ns
`include "spi_bridge_cfg.svh"

module subperipheral_selector (
    input  logic                          oscillator_clock,
    input  logic                          rst_n,
    input  spi_bridge_pkg::sub_request_t  request,
    input  logic                          transaction_active,
    input  spi_bridge_pkg::sub_response_t identity_response,
    input  spi_bridge_pkg::sub_response_t slot_response [`SLOT_COUNT],
    output logic                          identity_enable,
    output spi_bridge_pkg::slot_enable_t  slot_enable,
    output spi_bridge_pkg::sub_response_t response
);
    import spi_bridge_pkg::*;

    logic         decode_identity;
    slot_enable_t decode_slot;
    logic         unmapped_enable;
    logic         strobe_seen;

    always_comb begin
        decode_identity = (request.address == spi_address_t'(`CHIP_ID_ADDRESS)) ||
                          (request.address == spi_address_t'(`VERSION_ADDRESS));
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            decode_slot[i] = (request.address == spi_address_t'(`SLOT_BASE_ADDRESS + i));
        end
    end

    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            identity_enable <= 1'b0;
            slot_enable     <= '0;
            unmapped_enable <= 1'b0;
            strobe_seen     <= 1'b0;
        end else begin
            // unmapped answers follow every strobe by one cycle
            strobe_seen <= request.address_valid || request.data_valid;
            if (!transaction_active) begin
                identity_enable <= 1'b0;
                slot_enable     <= '0;
                unmapped_enable <= 1'b0;
            end else if (request.address_valid) begin
                identity_enable <= decode_identity;
                slot_enable     <= decode_slot;
                unmapped_enable <= !decode_identity && (decode_slot == '0);
            end
        end
    end

    // at most one enable is set, so the order here does not matter
    always_comb begin
        response = '{data: '0, valid: 1'b0};
        if (identity_enable) begin
            response = identity_response;
        end
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            if (slot_enable[i]) begin
                response = slot_response[i];
            end
        end
        if (unmapped_enable) begin
            response = '{data: byte_t'(`UNMAPPED_VALUE), valid: strobe_seen};
        end
    end

endmodule

/* src/identity_registers.sv */
/*
 Identity block. Answers with the chip identifier, or walks through the version
 string one byte per data strobe, depending on the transaction address.
*/
`timescale 1ns/1ns
`include "spi_bridge_cfg.svh"

module identity_registers (
    input  logic                          oscillator_clock,
    input  logic                          rst_n,
    input  logic                          enable,
    input  spi_bridge_pkg::sub_request_t  request,
    output spi_bridge_pkg::sub_response_t response
);
    import spi_bridge_pkg::*;

    localparam int index_width = $clog2(`VERSION_LENGTH);
    localparam logic [8*`VERSION_LENGTH-1:0] version_bytes = `VERSION_STRING;

    logic                   version_addressed;
    logic                   is_version;
    logic [index_width-1:0] index;
    logic [index_width-1:0] next_index;
    byte_t                  answer;
    logic                   answer_valid;

    // first character sits in the top byte of the string literal
    function automatic byte_t version_byte(input logic [index_width-1:0] position);
        return version_bytes[8*(`VERSION_LENGTH-1-position) +: 8];
    endfunction

    assign version_addressed = (request.address == spi_address_t'(`VERSION_ADDRESS));
    assign next_index = (index == index_width'(`VERSION_LENGTH - 1)) ? '0 : index + 1'b1;

    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            is_version   <= 1'b0;
            index        <= '0;
            answer       <= '0;
            answer_valid <= 1'b0;
        end else begin
            answer_valid <= 1'b0;
            if (request.address_valid) begin
                is_version   <= version_addressed;
                index        <= '0;
                answer       <= version_addressed ? version_byte('0) : byte_t'(`CHIP_ID_VALUE);
                answer_valid <= 1'b1;
            end else if (request.data_valid && enable) begin
                index        <= next_index;
                answer       <= is_version ? version_byte(next_index) : byte_t'(`CHIP_ID_VALUE);
                answer_valid <= 1'b1;
            end
        end
    end

    // the enable rises together with the answer to the address strobe
    assign response = '{data: answer, valid: answer_valid && enable};

endmodule

/* src/mailbox_slot.sv */
/*
 One mailbox slot, a small scratch buffer read back while it is written.
 Each data byte is stored at the pointer and the old byte at the next position is returned.
*/
`timescale 1ns/1ns
`include "spi_bridge_cfg.svh"

module mailbox_slot (
    input  logic                          oscillator_clock,
    input  logic                          rst_n,
    input  logic                          enable,
    input  spi_bridge_pkg::sub_request_t  request,
    output spi_bridge_pkg::sub_response_t response
);
    import spi_bridge_pkg::*;

    localparam int pointer_width = $clog2(`SLOT_DEPTH);

    byte_t                    memory [`SLOT_DEPTH];
    logic [pointer_width-1:0] pointer;
    logic [pointer_width-1:0] next_pointer;
    byte_t                    answer;
    logic                     answer_valid;

    assign next_pointer = (pointer == pointer_width'(`SLOT_DEPTH - 1)) ? '0 : pointer + 1'b1;

    always_ff @(posedge oscillator_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SLOT_DEPTH; i++) begin
                memory[i] <= '0;
            end
            pointer      <= '0;
            answer       <= '0;
            answer_valid <= 1'b0;
        end else begin
            answer_valid <= 1'b0;
            if (request.address_valid) begin
                // new transaction starts at byte 0
                pointer      <= '0;
                answer       <= memory[0];
                answer_valid <= 1'b1;
            end else if (request.data_valid && enable) begin
                memory[pointer] <= request.data;
                pointer         <= next_pointer;
                answer          <= memory[next_pointer];
                answer_valid    <= 1'b1;
            end
        end
    end

    // only the selected slot lets its answer through
    assign response = '{data: answer, valid: answer_valid && enable};

endmodule

/* src/spi_bridge_top.sv */
/*
 Top of the SPI register bridge. The peripheral feeds one request to every block,
 the selector picks the enabled block's response and returns it for transmission.
*/
`timescale 1ns/1ns
`include "spi_bridge_cfg.svh"

module spi_bridge_top (
    input  logic oscillator_clock,
    input  logic rst_n,
    input  logic spi_select_in,
    input  logic spi_clock_in,
    input  logic spi_data_in,
    output logic spi_data_out
);
    import spi_bridge_pkg::*;

    sub_request_t  request;
    sub_response_t response;
    sub_response_t identity_response;
    sub_response_t slot_response [`SLOT_COUNT];
    logic          transaction_active;
    logic          identity_enable;
    slot_enable_t  slot_enable;

    spi_peripheral u_peripheral (
        .oscillator_clock   (oscillator_clock),
        .rst_n              (rst_n),
        .spi_select_in      (spi_select_in),
        .spi_clock_in       (spi_clock_in),
        .spi_data_in        (spi_data_in),
        .spi_data_out       (spi_data_out),
        .transaction_active (transaction_active),
        .request            (request),
        .response           (response)
    );

    subperipheral_selector u_selector (
        .oscillator_clock   (oscillator_clock),
        .rst_n              (rst_n),
        .request            (request),
        .transaction_active (transaction_active),
        .identity_response  (identity_response),
        .slot_response      (slot_response),
        .identity_enable    (identity_enable),
        .slot_enable        (slot_enable),
        .response           (response)
    );

    identity_registers u_identity (
        .oscillator_clock (oscillator_clock),
        .rst_n            (rst_n),
        .enable           (identity_enable),
        .request          (request),
        .response         (identity_response)
    );

    // mailbox slots at consecutive addresses from the slot base
    for (genvar i = 0; i < `SLOT_COUNT; i++) begin : g_slot
        mailbox_slot u_slot (
            .oscillator_clock (oscillator_clock),
            .rst_n            (rst_n),
            .enable           (slot_enable[i]),
            .request          (request),
            .response         (slot_response[i])
        );
    end

endmodule

/* dv/spi_bridge_asserts.sv */
/*
 Protocol checks on request strobes, target enables and response valids.
 Bound into the bridge top by the testbench, failures are counted for the final report.
*/
`timescale 1ns/1ns

module spi_bridge_asserts (
    input logic                          oscillator_clock,
    input logic                          rst_n,
    input logic                          transaction_active,
    input spi_bridge_pkg::sub_request_t  request,
    input spi_bridge_pkg::sub_response_t response,
    input logic                          identity_enable,
    input spi_bridge_pkg::slot_enable_t  slot_enable
);
    import spi_bridge_pkg::*;

    logic strobe;
    int   failure_count = 0;

    assign strobe = request.address_valid || request.data_valid;

    // selector drives one target at a time
    one_enable: assert property (@(posedge oscillator_clock) disable iff (!rst_n)
        $onehot0({identity_enable, slot_enable}))
        else begin
            $error("more than one target enabled");
            failure_count++;
        end

    // every strobe gets exactly one answer, one cycle later
    answer_follows_strobe: assert property (@(posedge oscillator_clock) disable iff (!rst_n)
        strobe |=> response.valid)
        else begin
            $error("no response valid in the cycle after a strobe");
            failure_count++;
        end

    answer_needs_strobe: assert property (@(posedge oscillator_clock) disable iff (!rst_n)
        response.valid |-> $past(strobe))
        else begin
            $error("response valid without a strobe in the cycle before");
            failure_count++;
        end

    strobe_inside_transaction: assert property (@(posedge oscillator_clock) disable iff (!rst_n)
        !transaction_active |-> !strobe)
        else begin
            $error("strobe while chip select is high");
            failure_count++;
        end

    // from reset on, an idle bus leaves no strobe, enable or answer one cycle later
    quiet_while_idle: assert property (@(posedge oscillator_clock) disable iff (!rst_n)
        !transaction_active |=>
            !strobe && !response.valid && !identity_enable && (slot_enable == '0))
        else begin
            $error("strobe, enable or valid set while chip select is high");
            failure_count++;
        end

endmodule

/* dv/spi_bridge_tb.sv */
/*
 Testbench for the SPI register bridge. Acts as a mode 0 SPI controller and checks
 every byte on spi_data_out against a model of the register map.
*/
`timescale 1ns/1ns
`include "spi_bridge_cfg.svh"

module spi_bridge_tb;
    import spi_bridge_pkg::*;

    localparam int half_period = 8;
    // 197 bytes over all tests, 16 clocks per bit, four times as the limit
    localparam int timeout_cycles = 4 * 197 * 8 * 2 * half_period;

    logic  oscillator_clock = 1'b0;
    logic  rst_n;
    logic  spi_select_in;
    logic  spi_clock_in;
    logic  spi_data_in;
    logic  spi_data_out;

    byte_t slot_model [`SLOT_COUNT][`SLOT_DEPTH];
    byte_t send_data [1:16];
    byte_t expected_bytes [$];
    byte_t received_bytes [$];
    int    cycle_count = 0;
    int    error_count = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    test_errors = 0;
    int    seed_value;

    spi_bridge_top u_dut (
        .oscillator_clock (oscillator_clock),
        .rst_n            (rst_n),
        .spi_select_in    (spi_select_in),
        .spi_clock_in     (spi_clock_in),
        .spi_data_in      (spi_data_in),
        .spi_data_out     (spi_data_out)
    );

    bind spi_bridge_top spi_bridge_asserts u_asserts (
        .oscillator_clock   (oscillator_clock),
        .rst_n              (rst_n),
        .transaction_active (transaction_active),
        .request            (request),
        .response           (response),
        .identity_enable    (identity_enable),
        .slot_enable        (slot_enable)
    );

    always #5 oscillator_clock = ~oscillator_clock;

    // expected byte on spi_data_out, position 0 is the address slot
    function automatic byte_t reference_byte(input spi_address_t address, input int position);
        int                            slot;
        logic [8*`VERSION_LENGTH-1:0] version_text;
        slot = int'(address) - int'(`SLOT_BASE_ADDRESS);
        version_text = `VERSION_STRING;
        if (position == 0)
            return 8'h00;
        if (address == `CHIP_ID_ADDRESS)
            return `CHIP_ID_VALUE;
        if (address == `VERSION_ADDRESS)
            return version_text[8*(`VERSION_LENGTH-1-((position-1) % `VERSION_LENGTH)) +: 8];
        if (slot < 0 || slot >= `SLOT_COUNT)
            return `UNMAPPED_VALUE;
        // past the depth the pointer wraps onto bytes written earlier in this transaction
        if (position > `SLOT_DEPTH)
            return send_data[position - `SLOT_DEPTH];
        return slot_model[slot][position-1];
    endfunction

    task automatic commit_writes(input spi_address_t address, input int count);
        int slot;
        slot = int'(address) - int'(`SLOT_BASE_ADDRESS);
        if (slot >= 0 && slot < `SLOT_COUNT) begin
            for (int k = 1; k <= count; k++) begin
                slot_model[slot][(k-1) % `SLOT_DEPTH] = send_data[k];
            end
        end
    endtask

    function automatic spi_address_t unmapped_address();
        spi_address_t address;
        do begin
            address = spi_address_t'($urandom);
        end while (address == `CHIP_ID_ADDRESS || address == `VERSION_ADDRESS ||
                   (address >= `SLOT_BASE_ADDRESS &&
                    address < `SLOT_BASE_ADDRESS + `SLOT_COUNT));
        return address;
    endfunction

    task automatic fill_random(input int count);
        for (int k = 1; k <= count; k++) begin
            send_data[k] = byte_t'($urandom);
        end
    endtask

    task automatic check_byte(input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            $display("mismatch spi_data_out: got 0x%02h, expected 0x%02h", actual, expected);
            error_count++;
        end
    endtask

    // mode 0, copi set while SCLK is low, cipo sampled just before the rising edge
    task automatic transfer_byte(input byte_t copi, output byte_t cipo);
        for (int b = 7; b >= 0; b--) begin
            spi_data_in = copi[b];
            repeat (half_period) @(negedge oscillator_clock);
            cipo[b] = spi_data_out;
            spi_clock_in = 1'b1;
            repeat (half_period) @(negedge oscillator_clock);
            spi_clock_in = 1'b0;
        end
    endtask

    task automatic run_transaction(input spi_address_t address, input int count);
        byte_t reply;
        for (int p = 0; p <= count; p++) begin
            expected_bytes.push_back(reference_byte(address, p));
        end
        commit_writes(address, count);
        spi_select_in = 1'b0;
        repeat (half_period) @(negedge oscillator_clock);
        transfer_byte(address, reply);
        received_bytes.push_back(reply);
        for (int k = 1; k <= count; k++) begin
            transfer_byte(send_data[k], reply);
            received_bytes.push_back(reply);
        end
        repeat (half_period) @(negedge oscillator_clock);
        spi_select_in = 1'b1;
        repeat (2 * half_period) @(negedge oscillator_clock);
    endtask

    task automatic finish_test(input string name);
        while (received_bytes.size() > 0) begin
            @(negedge oscillator_clock);
        end
        if (error_count == test_errors) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d mismatches", name, error_count - test_errors);
            tests_failed++;
        end
        test_errors = error_count;
    endtask

    // compares received bytes with the model in arrival order
    always @(posedge oscillator_clock) begin
        if (received_bytes.size() > 0 && expected_bytes.size() > 0) begin
            check_byte(received_bytes.pop_front(), expected_bytes.pop_front());
        end
    end

    always @(posedge oscillator_clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed_value = $urandom(3759);
        rst_n = 1'b0;
        spi_select_in = 1'b1;
        spi_clock_in = 1'b0;
        spi_data_in = 1'b0;
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            for (int i = 0; i < `SLOT_DEPTH; i++) begin
                slot_model[s][i] = 8'h00;
            end
        end
        repeat (3) @(negedge oscillator_clock);
        rst_n = 1'b1;
        repeat (4) @(negedge oscillator_clock);

        fill_random(3);
        run_transaction(`CHIP_ID_ADDRESS, 3);
        finish_test("chip identifier");

        fill_random(6);
        run_transaction(`VERSION_ADDRESS, 6);
        finish_test("version string");

        for (int s = 0; s < `SLOT_COUNT; s++) begin
            fill_random(8);
            run_transaction(`SLOT_BASE_ADDRESS + s, 8);
            fill_random(8);
            run_transaction(`SLOT_BASE_ADDRESS + s, 8);
        end
        finish_test("mailbox write and read back");

        fill_random(8);
        run_transaction(`SLOT_BASE_ADDRESS + 1, 8);
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            fill_random(8);
            run_transaction(`SLOT_BASE_ADDRESS + s, 8);
        end
        finish_test("mailbox isolation");

        for (int n = 0; n < 4; n++) begin
            fill_random(4);
            run_transaction(unmapped_address(), 4);
        end
        for (int s = 0; s < `SLOT_COUNT; s++) begin
            fill_random(8);
            run_transaction(`SLOT_BASE_ADDRESS + s, 8);
        end
        finish_test("unmapped addresses");

        fill_random(12);
        run_transaction(`SLOT_BASE_ADDRESS + 2, 12);
        finish_test("mailbox pointer wrap");

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, u_dut.u_asserts.failure_count);
        if (tests_failed == 0 && u_dut.u_asserts.failure_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+src
src/spi_bridge_pkg.sv
src/spi_peripheral.sv
src/subperipheral_selector.sv
src/identity_registers.sv
src/mailbox_slot.sv
src/spi_bridge_top.sv
dv/spi_bridge_asserts.sv
dv/spi_bridge_tb.sv
